// File: hdl/fpm_defines.svh
/*
 * Width, bias and tiling constants of the double-precision multiplier.
 * Included by the packages, the RTL and the testbench.
 */
`ifndef FPM_DEFINES_SVH
`define FPM_DEFINES_SVH

// IEEE 754 binary64 layout
`define FP_EXP_W  11
`define FP_MANT_W 52
`define FP_BIAS   1023
`define FP_W      64

// Significand tiling, seven 8-bit lanes per operand
`define TILE_W    8
`define TILE_N    7
`define SIG_W     (`TILE_W * `TILE_N)

// Product bit that decides the normalization shift
`define NORM_BIT  105

`endif

// File: hdl/fp64_pkg.sv
/*
 * Types for the IEEE double word: exponent, mantissa and the word itself,
 * which is read either as raw bits or as sign, exponent and mantissa fields.
 */
`include "fpm_defines.svh"

package fp64_pkg;

	typedef logic [`FP_EXP_W-1:0] fp_exp_t;

	typedef logic [`FP_MANT_W-1:0] fp_mant_t;

	typedef struct packed {
		logic     sign;
		fp_exp_t  exp;
		fp_mant_t mant;
	} fp64_fields_t;

	// One 64-bit word, two decodings
	typedef union packed {
		logic [`FP_W-1:0] raw;
		fp64_fields_t     f;
	} fp64_t;

endpackage

// File: hdl/mant_pkg.sv
/*
 * Types for the significand datapath: single lanes, lane products,
 * extended significands and the full significand product.
 */
`include "fpm_defines.svh"

package mant_pkg;

	typedef logic [`TILE_W-1:0] tile_t;

	typedef logic [2*`TILE_W-1:0] tile_prod_t;

	// Hidden 1 and mantissa, zero-extended to whole lanes
	typedef logic [`SIG_W-1:0] sig_t;

	typedef logic [2*`SIG_W-1:0] sig_prod_t;

endpackage

// File: hdl/prod_if.sv
/*
 * Stage-1 results handed from the operand stage to the packing stage.
 * No handshake, valid is a one-cycle strobe per item.
 */
interface prod_if import fp64_pkg::*, mant_pkg::*;;

	logic      valid;
	logic      sign;
	fp_exp_t   exp_sum;
	logic      special;
	sig_prod_t sig_prod;

	modport src (
		output valid,
		output sign,
		output exp_sum,
		output special,
		output sig_prod
	);

	modport dst (
		input valid,
		input sign,
		input exp_sum,
		input special,
		input sig_prod
	);

endinterface

// File: hdl/tile_mult8.sv
/*
 * Combinational 8x8 unsigned multiplier. Partial-product rows go through
 * four layers of carry-save compression and one ripple carry adder.
 */
`include "fpm_defines.svh"

module tile_mult8 import mant_pkg::*; (
	input  tile_t      x,
	input  tile_t      y,
	output tile_prod_t p
);

	tile_prod_t row [`TILE_W];
	tile_prod_t s1, c1, s2, c2;
	tile_prod_t s3, c3, s4, c4;
	tile_prod_t s5, c5;
	tile_prod_t s6, c6;

	// 3:2 compressor across a whole row, carries move up one column
	function automatic tile_prod_t csa_sum(input tile_prod_t a, input tile_prod_t b,
			input tile_prod_t c);
		return a ^ b ^ c;
	endfunction

	function automatic tile_prod_t csa_carry(input tile_prod_t a, input tile_prod_t b,
			input tile_prod_t c);
		return ((a & b) | (a & c) | (b & c)) << 1;
	endfunction

	for (genvar i = 0; i < `TILE_W; i++) begin : g_row
		assign row[i] = tile_prod_t'(x & {`TILE_W{y[i]}}) << i;
	end

	// Columns where one input is a constant zero reduce to 2:2 compressors

	// Layer 1, rows 0-2 and 3-5
	assign s1 = csa_sum(row[0], row[1], row[2]);
	assign c1 = csa_carry(row[0], row[1], row[2]);
	assign s2 = csa_sum(row[3], row[4], row[5]);
	assign c2 = csa_carry(row[3], row[4], row[5]);

	// Layer 2, rows 6 and 7 join here
	assign s3 = csa_sum(s1, c1, s2);
	assign c3 = csa_carry(s1, c1, s2);
	assign s4 = csa_sum(c2, row[6], row[7]);
	assign c4 = csa_carry(c2, row[6], row[7]);

	// Layer 3
	assign s5 = csa_sum(s3, c3, s4);
	assign c5 = csa_carry(s3, c3, s4);

	// Layer 4, the carries of layer 2 catch up
	assign s6 = csa_sum(s5, c5, c4);
	assign c6 = csa_carry(s5, c5, c4);

	// Final ripple carry adder
	always_comb begin
		logic carry;
		carry = 1'b0;
		for (int k = 0; k < 2*`TILE_W; k++) begin
			p[k] = s6[k] ^ c6[k] ^ carry;
			carry = (s6[k] & c6[k]) | (carry & (s6[k] ^ c6[k]));
		end
	end

endmodule

// File: hdl/mant_mult.sv
/*
 * Combinational 56x56 significand multiplier. Every lane pair goes through
 * one tile, and the shifted tile products are summed by a binary adder tree.
 */
`include "fpm_defines.svh"

module mant_mult import mant_pkg::*; (
	input  sig_t      sa,
	input  sig_t      sb,
	output sig_prod_t prod
);

	localparam int TILES = `TILE_N * `TILE_N;
	localparam int LEAVES = 2 ** $clog2(TILES);

	// Heap-ordered tree, node k sums nodes 2k and 2k+1, leaves hold tiles
	sig_prod_t node [1:2*LEAVES-1];

	for (genvar i = 0; i < `TILE_N; i++) begin : g_lane_a
		for (genvar j = 0; j < `TILE_N; j++) begin : g_lane_b
			tile_prod_t tp;

			tile_mult8 u_tile (
				.x(sa[i*`TILE_W +: `TILE_W]),
				.y(sb[j*`TILE_W +: `TILE_W]),
				.p(tp)
			);

			assign node[LEAVES + i*`TILE_N + j] = sig_prod_t'(tp) << ((i + j) * `TILE_W);
		end
	end

	// Unused leaves
	for (genvar n = TILES; n < LEAVES; n++) begin : g_pad
		assign node[LEAVES + n] = '0;
	end

	for (genvar k = 1; k < LEAVES; k++) begin : g_add
		assign node[k] = node[2*k] + node[2*k+1];
	end

	assign prod = node[1];

endmodule

// File: hdl/operand_stage.sv
/*
 * First pipeline stage. Decodes both operands, multiplies the significands
 * and registers sign, exponent sum, special flag and product one cycle later.
 */
`include "fpm_defines.svh"

module operand_stage import fp64_pkg::*, mant_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  bit    in_valid,
	input  fp64_t a,
	input  fp64_t b,
	prod_if.src   out
);

	sig_t      sig_a;
	sig_t      sig_b;
	sig_prod_t sig_prod;
	logic      sign;
	fp_exp_t   exp_sum;
	logic      special;

	// Hidden 1 is set for every operand, zeros and subnormals included
	assign sig_a = sig_t'({1'b1, a.f.mant});
	assign sig_b = sig_t'({1'b1, b.f.mant});

	// Sign taken from the top bit of the raw word
	assign sign = a.raw[`FP_W-1] ^ b.raw[`FP_W-1];

	// Wraps to 11 bits on overflow or underflow
	assign exp_sum = fp_exp_t'(a.f.exp + b.f.exp - `FP_BIAS);
	assign special = (&a.f.exp) | (&b.f.exp);

	mant_mult u_mant_mult (
		.sa(sig_a),
		.sb(sig_b),
		.prod(sig_prod)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out.sign <= sign;
			out.exp_sum <= exp_sum;
			out.special <= special;
			out.sig_prod <= sig_prod;
		end
	end

endmodule

// File: hdl/fp_pack.sv
/*
 * Second pipeline stage. Normalizes the significand product on bit 105,
 * truncates to 52 mantissa bits and registers the packed result word.
 */
`include "fpm_defines.svh"

module fp_pack import fp64_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	prod_if.dst   in,
	output bit    out_valid,
	output fp64_t product
);

	fp64_t res;

	always_comb begin
		res.f.sign = in.sign;
		if (in.special) begin
			// Either exponent all ones
			res.f.exp = '1;
			res.f.mant = '0;
		end else if (in.sig_prod[`NORM_BIT]) begin
			res.f.exp = in.exp_sum + 1'b1;
			res.f.mant = in.sig_prod[`NORM_BIT-1 -: `FP_MANT_W];
		end else begin
			res.f.exp = in.exp_sum;
			res.f.mant = in.sig_prod[`NORM_BIT-2 -: `FP_MANT_W];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			product.raw <= res.raw;
		end
	end

endmodule

// File: hdl/fp_mult.sv
/*
 * Top level of the two-stage double-precision multiplier.
 * in_valid at edge k gives out_valid and the product after edge k+2.
 */
`include "fpm_defines.svh"

module fp_mult (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [`FP_W-1:0] a,
	input  logic [`FP_W-1:0] b,
	output logic             out_valid,
	output logic [`FP_W-1:0] product
);

	// Stage 1 to stage 2
	prod_if stage_if ();

	operand_stage u_operand_stage (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.a(a),
		.b(b),
		.out(stage_if.src)
	);

	fp_pack u_fp_pack (
		.clk(clk),
		.rst_n(rst_n),
		.in(stage_if.dst),
		.out_valid(out_valid),
		.product(product)
	);

endmodule

// File: verif/fp_mult_asserts.sv
/*
 * Concurrent checks on the multiplier's valid pipeline and output word.
 * Bound into fp_mult, no instance is needed in the testbench.
 */
`include "fpm_defines.svh"

module fp_mult_asserts (
	input logic             clk,
	input logic             rst_n,
	input logic             in_valid,
	input logic             out_valid,
	input logic [`FP_W-1:0] product
);
	timeunit 1ns;
	timeprecision 1ps;

	// Two register stages between in_valid and out_valid
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	a_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(product))
		else $error("product has unknown bits while out_valid is high");

endmodule

bind fp_mult fp_mult_asserts i_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.product(product)
);

// File: verif/tb_fp_mult.sv
/*
 * Testbench for the pipelined double multiplier. Applies a table of known
 * products, then a random stream with gaps checked against a reference model.
 */
`include "fpm_defines.svh"

module tb_fp_mult;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		logic [`FP_W-1:0] a;
		logic [`FP_W-1:0] b;
		logic [`FP_W-1:0] prod;
	} vec_t;

	logic             clk;
	logic             rst_n;
	logic             in_valid;
	logic [`FP_W-1:0] a;
	logic [`FP_W-1:0] b;
	logic             out_valid;
	logic [`FP_W-1:0] product;

	vec_t             vectors [0:6];
	logic [`FP_W-1:0] exp_q [$];
	logic [1:0]       vld_hist;
	integer           seed;

	fp_mult i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.a(a),
		.b(b),
		.out_valid(out_valid),
		.product(product)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [`FP_W-1:0] got,
			input logic [`FP_W-1:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Sign XOR, biased exponent sum, normalization on the top product bit
	function automatic logic [`FP_W-1:0] model_product(input logic [`FP_W-1:0] x,
			input logic [`FP_W-1:0] y);
		logic [2*`FP_MANT_W+1:0] sx;
		logic [2*`FP_MANT_W+1:0] sy;
		logic [2*`FP_MANT_W+1:0] full;
		logic [`FP_EXP_W-1:0]    ex;
		logic [`FP_EXP_W-1:0]    ey;
		logic [`FP_EXP_W-1:0]    e;
		logic [`FP_MANT_W-1:0]   m;
		ex = x[`FP_W-2 -: `FP_EXP_W];
		ey = y[`FP_W-2 -: `FP_EXP_W];
		sx = '0;
		sy = '0;
		sx[`FP_MANT_W:0] = {1'b1, x[`FP_MANT_W-1:0]};
		sy[`FP_MANT_W:0] = {1'b1, y[`FP_MANT_W-1:0]};
		full = sx * sy;
		e = ex + ey - 11'(`FP_BIAS);
		if (full[2*`FP_MANT_W+1]) begin
			m = full[2*`FP_MANT_W -: `FP_MANT_W];
			e = e + 11'd1;
		end else begin
			m = full[2*`FP_MANT_W-1 -: `FP_MANT_W];
		end
		if ((&ex) || (&ey)) begin
			e = '1;
			m = '0;
		end
		return {x[`FP_W-1] ^ y[`FP_W-1], e, m};
	endfunction

	task automatic send(input logic [`FP_W-1:0] op_a, input logic [`FP_W-1:0] op_b,
			input logic [`FP_W-1:0] expected);
		@(posedge clk);
		in_valid <= 1'b1;
		a <= op_a;
		b <= op_b;
		exp_q.push_back(expected);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				$display("Timeout, %0d results never came out", exp_q.size());
				$display("sim failed");
				$fatal(1, "timeout");
			end
		end
	endtask

	// Output monitor, sampled away from the rising edge
	initial begin
		vld_hist = 2'b00;
		// Start once the clock runs
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_value("out_valid", 64'(out_valid), 64'(vld_hist[1]));
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Output at %0t has no matching input", $time);
					$display("sim failed");
					$fatal(1, "unexpected output");
				end
				check_value("product", product, exp_q.pop_front());
			end
			vld_hist = {vld_hist[0], in_valid};
		end
	end

	initial begin
		logic [`FP_W-1:0] ra;
		logic [`FP_W-1:0] rb;
		int gap;
		seed = 32'hc1b2_bcb0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		vectors[0] = '{64'h3ff0_0000_0000_0000, 64'h3ff0_0000_0000_0000, 64'h3ff0_0000_0000_0000};
		vectors[1] = '{64'h3ff8_0000_0000_0000, 64'h4000_0000_0000_0000, 64'h4008_0000_0000_0000};
		// 1.5 x 1.5 takes the normalization shift
		vectors[2] = '{64'h3ff8_0000_0000_0000, 64'h3ff8_0000_0000_0000, 64'h4002_0000_0000_0000};
		vectors[3] = '{64'hc000_0000_0000_0000, 64'h4008_0000_0000_0000, 64'hc018_0000_0000_0000};
		// All-ones exponent on either side
		vectors[4] = '{64'h7ff0_0000_0000_0000, 64'h3ff0_0000_0000_0000, 64'h7ff0_0000_0000_0000};
		vectors[5] = '{64'hfff8_0000_0000_0001, 64'h4000_0000_0000_0000, 64'hfff0_0000_0000_0000};
		vectors[6] = '{64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0005, 64'hfff0_0000_0000_0000};

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(negedge clk);
		check_value("out_valid", 64'(out_valid), 64'd0);

		for (int i = 0; i < 7; i++) begin
			check_value("model_product", model_product(vectors[i].a, vectors[i].b),
				vectors[i].prod);
			send(vectors[i].a, vectors[i].b, vectors[i].prod);
		end
		idle_cycle();
		wait_drained();

		for (int n = 0; n < 300; n++) begin
			ra = {$random(seed), $random(seed)};
			rb = {$random(seed), $random(seed)};
			if (($random(seed) & 15) == 0) begin
				ra[`FP_W-2 -: `FP_EXP_W] = '1;
			end
			send(ra, rb, model_product(ra, rb));
			gap = $random(seed) & 7;
			if (gap >= 5) begin
				repeat (gap - 4) idle_cycle();
			end
		end
		idle_cycle();
		wait_drained();
		repeat (4) @(negedge clk);

		$display("sim passed");
		$finish;
	end

endmodule

// File: list.f
+incdir+hdl
hdl/fp64_pkg.sv
hdl/mant_pkg.sv
hdl/prod_if.sv
hdl/tile_mult8.sv
hdl/mant_mult.sv
hdl/operand_stage.sv
hdl/fp_pack.sv
hdl/fp_mult.sv
verif/fp_mult_asserts.sv
verif/tb_fp_mult.sv

// File: run.sh
#!/bin/sh
# Build the multiplier and its testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_fp_mult -f list.f \
	-o tb_fp_mult > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_fp_mult > sim.log 2>&1
grep -q "sim failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "sim passed" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation PASSED"
exit 0
